// ==== common/pipemips_settings.svh ====
`ifndef PIPEMIPS_SETTINGS_SVH
`define PIPEMIPS_SETTINGS_SVH

// datapath widths
`define PM_XLEN      32
`define PM_REG_ADDR  5
`define PM_NUM_REGS  32
`define PM_OP_W      6
`define PM_FN_W      6
`define PM_IMM_W     16

// opcodes, everything else gives no writeback
`define PM_OP_RTYPE  6'd1
`define PM_OP_ADDI   6'd5

// R-type funct codes
`define PM_FN_ADD    6'd1
`define PM_FN_SUB    6'd2
`define PM_FN_AND    6'd4
`define PM_FN_OR     6'd8
`define PM_FN_MUL    6'd24

`define PM_MUL_STAGES 4 // multiply pipe depth
`define PM_WBQ_DEPTH  4 // writeback queue entries, power of two

`endif

// ==== common/pipemips_pkg.sv ====
`include "pipemips_settings.svh"

package pipemips_pkg;

	// R-type view
	typedef struct packed {
		logic [`PM_OP_W-1:0]     opcode;
		logic [`PM_REG_ADDR-1:0] rs;
		logic [`PM_REG_ADDR-1:0] rt;
		logic [`PM_REG_ADDR-1:0] rd;
		logic [`PM_REG_ADDR-1:0] shamt;
		logic [`PM_FN_W-1:0]     funct;
	} r_fields_t;

	// immediate view, same word
	typedef struct packed {
		logic [`PM_OP_W-1:0]     opcode;
		logic [`PM_REG_ADDR-1:0] rs;
		logic [`PM_REG_ADDR-1:0] rt;
		logic [`PM_IMM_W-1:0]    imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} instr_t;

	// which execution pipe takes the instruction
	typedef enum logic [1:0] {
		UNIT_NONE = 2'd0,
		UNIT_ALU  = 2'd1,
		UNIT_MUL  = 2'd2
	} unit_t;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_OR  = 2'd3
	} alu_op_t;

	typedef struct packed {
		logic                    valid;
		unit_t                   unit;
		alu_op_t                 alu_op;
		logic [`PM_REG_ADDR-1:0] dest;
		logic [`PM_XLEN-1:0]     opa;
		logic [`PM_XLEN-1:0]     opb; // immediate already merged for addi
	} issue_t;

	typedef struct packed {
		logic                    valid;
		logic [`PM_REG_ADDR-1:0] dest;
		logic [`PM_XLEN-1:0]     data;
	} wb_t;

endpackage

// ==== logic/decode_issue.sv ====
`timescale 1ns/1ps
`include "pipemips_settings.svh"

module decode_issue
	import pipemips_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_inst_valid,
	input  instr_t                  i_inst,
	input  logic [`PM_XLEN-1:0]     i_rdata_a,
	input  logic [`PM_XLEN-1:0]     i_rdata_b,
	output logic [`PM_REG_ADDR-1:0] o_raddr_a,
	output logic [`PM_REG_ADDR-1:0] o_raddr_b,
	output issue_t                  o_issue
);

	issue_t issue_next;
	unit_t unit;
	alu_op_t alu_op;
	logic [`PM_REG_ADDR-1:0] dest;
	logic [`PM_XLEN-1:0] opb;

	// rs and rt sit in the same place in both views
	assign o_raddr_a = i_inst.r_fields.rs;
	assign o_raddr_b = i_inst.r_fields.rt;

	always_comb
	begin
		unit   = UNIT_NONE;
		alu_op = ALU_ADD;
		dest   = i_inst.r_fields.rd;
		opb    = i_rdata_b;
		case (i_inst.r_fields.opcode)
			`PM_OP_RTYPE:
			begin
				case (i_inst.r_fields.funct)
					`PM_FN_ADD:
					begin
						unit   = UNIT_ALU;
						alu_op = ALU_ADD;
					end
					`PM_FN_SUB:
					begin
						unit   = UNIT_ALU;
						alu_op = ALU_SUB;
					end
					`PM_FN_AND:
					begin
						unit   = UNIT_ALU;
						alu_op = ALU_AND;
					end
					`PM_FN_OR:
					begin
						unit   = UNIT_ALU;
						alu_op = ALU_OR;
					end
					`PM_FN_MUL: unit = UNIT_MUL;
					default:    unit = UNIT_NONE; // unknown funct is dropped
				endcase
			end
			`PM_OP_ADDI:
			begin
				unit   = UNIT_ALU;
				alu_op = ALU_ADD;
				dest   = i_inst.i_fields.rt; // addi writes rt
				opb    = {{(`PM_XLEN-`PM_IMM_W){1'b0}}, i_inst.i_fields.imm};
			end
			default: unit = UNIT_NONE; // nop, lw, sw, beq and the rest
		endcase
	end

	always_comb
	begin
		issue_next.valid  = i_inst_valid;
		issue_next.unit   = unit;
		issue_next.alu_op = alu_op;
		issue_next.dest   = dest;
		issue_next.opa    = i_rdata_a;
		issue_next.opb    = opb;
	end

	// one issue record per strobe, payload follows along every cycle
	always_ff @(posedge clk)
	begin
		if (!rst)
			o_issue.valid <= 1'b0;
		else
			o_issue <= issue_next;
	end

endmodule

// ==== logic/register_bank.sv ====
`timescale 1ns/1ps
`include "pipemips_settings.svh"

module register_bank
	import pipemips_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`PM_REG_ADDR-1:0] i_raddr_a,
	input  logic [`PM_REG_ADDR-1:0] i_raddr_b,
	input  wb_t                     i_wb,
	output logic [`PM_XLEN-1:0]     o_rdata_a,
	output logic [`PM_XLEN-1:0]     o_rdata_b
);

	logic [`PM_XLEN-1:0] regs [`PM_NUM_REGS];

	// write data is forwarded to a read of the same register
	assign o_rdata_a = (i_wb.valid && i_wb.dest == i_raddr_a) ? i_wb.data : regs[i_raddr_a];
	assign o_rdata_b = (i_wb.valid && i_wb.dest == i_raddr_b) ? i_wb.data : regs[i_raddr_b];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			// register i starts out holding i
			for (int i = 0; i < `PM_NUM_REGS; i++)
				regs[i] <= `PM_XLEN'(i);
		end
		else if (i_wb.valid)
		begin
			regs[i_wb.dest] <= i_wb.data;
		end
	end

endmodule

// ==== execute/alu_unit.sv ====
`timescale 1ns/1ps
`include "pipemips_settings.svh"

module alu_unit
	import pipemips_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  issue_t i_issue,
	output wb_t    o_done
);

	logic [`PM_XLEN-1:0] result;
	logic take;

	// both pipes see the record, only ours is picked up here
	assign take = i_issue.valid && (i_issue.unit == UNIT_ALU);

	always_comb
	begin
		case (i_issue.alu_op)
			ALU_ADD: result = i_issue.opa + i_issue.opb;
			ALU_SUB: result = i_issue.opa - i_issue.opb;
			ALU_AND: result = i_issue.opa & i_issue.opb;
			ALU_OR:  result = i_issue.opa | i_issue.opb;
			default: result = '0;
		endcase
	end

	// single result stage
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			o_done.valid <= 1'b0;
		end
		else
		begin
			o_done.valid <= take;
			o_done.dest  <= i_issue.dest;
			o_done.data  <= result;
		end
	end

endmodule

// ==== execute/mul_pipe.sv ====
`timescale 1ns/1ps
`include "pipemips_settings.svh"

module mul_pipe
	import pipemips_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  issue_t i_issue,
	output wb_t    o_done
);

	wb_t entry;
	wb_t stage [`PM_MUL_STAGES];

	// product formed at entry, the stages only delay it
	always_comb
	begin
		entry.valid = i_issue.valid && (i_issue.unit == UNIT_MUL);
		entry.dest  = i_issue.dest;
		entry.data  = i_issue.opa * i_issue.opb; // low word only
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int s = 0; s < `PM_MUL_STAGES; s++)
				stage[s].valid <= 1'b0;
		end
		else
		begin
			stage[0] <= entry;
			for (int s = 1; s < `PM_MUL_STAGES; s++)
				stage[s] <= stage[s-1];
		end
	end

	assign o_done = stage[`PM_MUL_STAGES-1];

endmodule

// ==== logic/writeback_queue.sv ====
`timescale 1ns/1ps
`include "pipemips_settings.svh"

module writeback_queue
	import pipemips_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  wb_t  i_alu_done,
	input  wb_t  i_mul_done,
	output wb_t  o_wb
);

	localparam int PTR_W = $clog2(`PM_WBQ_DEPTH);

	wb_t mem [`PM_WBQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] wr_ptr_1;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic [PTR_W:0] total; // stored plus arriving
	logic [1:0] n_in;
	logic pop;
	wb_t first_in;
	wb_t head;

	// alu goes ahead of mul on a tie
	assign first_in = i_alu_done.valid ? i_alu_done : i_mul_done;
	assign n_in     = {1'b0, i_alu_done.valid} + {1'b0, i_mul_done.valid};
	assign total    = count + (PTR_W+1)'(n_in);
	assign pop      = (total != '0);
	assign wr_ptr_1 = wr_ptr + PTR_W'(1);

	// empty queue lets the first arrival straight through
	assign head = (count != '0) ? mem[rd_ptr] : first_in;

	// arrivals are always written, the bypassed one is skipped by rd_ptr
	always_ff @(posedge clk)
	begin
		if (first_in.valid)
			mem[wr_ptr] <= first_in;
		if (i_alu_done.valid && i_mul_done.valid)
			mem[wr_ptr_1] <= i_mul_done;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			o_wb.valid   <= 1'b0;
		end
		else
		begin
			wr_ptr <= wr_ptr + PTR_W'(n_in);
			if (pop)
				rd_ptr <= rd_ptr + PTR_W'(1);
			count <= total - (PTR_W+1)'(pop);
			o_wb  <= head; // valid low when nothing is held or arriving
		end
	end

endmodule

// ==== logic/pipemips.sv ====
`timescale 1ns/1ps
`include "pipemips_settings.svh"

module pipemips
	import pipemips_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   i_inst_valid,
	input  instr_t i_inst,
	output wb_t    o_wb
);

	logic [`PM_REG_ADDR-1:0] raddr_a;
	logic [`PM_REG_ADDR-1:0] raddr_b;
	logic [`PM_XLEN-1:0] rdata_a;
	logic [`PM_XLEN-1:0] rdata_b;
	issue_t issue;
	wb_t alu_done;
	wb_t mul_done;

	decode_issue u_decode_issue (
		.clk          (clk),
		.rst          (rst),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.i_rdata_a    (rdata_a),
		.i_rdata_b    (rdata_b),
		.o_raddr_a    (raddr_a),
		.o_raddr_b    (raddr_b),
		.o_issue      (issue)
	);

	// write port fed by the commit record
	register_bank u_register_bank (
		.clk       (clk),
		.rst       (rst),
		.i_raddr_a (raddr_a),
		.i_raddr_b (raddr_b),
		.i_wb      (o_wb),
		.o_rdata_a (rdata_a),
		.o_rdata_b (rdata_b)
	);

	alu_unit u_alu_unit (.clk(clk), .rst(rst), .i_issue(issue), .o_done(alu_done));

	mul_pipe u_mul_pipe (.clk(clk), .rst(rst), .i_issue(issue), .o_done(mul_done));

	writeback_queue u_writeback_queue (
		.clk        (clk),
		.rst        (rst),
		.i_alu_done (alu_done),
		.i_mul_done (mul_done),
		.o_wb       (o_wb)
	);

endmodule

// ==== tests/pipemips_tb.sv ====
`timescale 1ns/1ps
`include "pipemips_settings.svh"

module pipemips_tb
	import pipemips_pkg::*;
();

	localparam int SCHED = 1024;
	localparam int DRAIN_LIMIT = 60;

	logic clk;
	logic rst;
	logic i_inst_valid;
	instr_t i_inst;
	wb_t o_wb;

	// stimulus table: word, idle cycles after the strobe, expected data
	instr_t tbl_inst [$];
	int tbl_gap [$];
	logic [`PM_XLEN-1:0] tbl_exp [$];
	bit tbl_fixed [$]; // clear on random rows, the model supplies the value

	// reference model
	logic [`PM_XLEN-1:0] model_regs [`PM_NUM_REGS];
	wb_t alu_sched [SCHED]; // results reaching the queue model in that cycle
	wb_t mul_sched [SCHED];
	wb_t pend_q [$];
	int cyc;
	int issued;
	int commits_seen;
	int errors;
	int checks;
	int seed;

	pipemips dut (
		.clk          (clk),
		.rst          (rst),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.o_wb         (o_wb)
	);

	always #4 clk = ~clk;

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	function automatic instr_t r_word(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd);
		instr_t w;
		w.r_fields.opcode = `PM_OP_RTYPE;
		w.r_fields.rs     = rs;
		w.r_fields.rt     = rt;
		w.r_fields.rd     = rd;
		w.r_fields.shamt  = 5'd0;
		w.r_fields.funct  = funct;
		return w;
	endfunction

	function automatic instr_t i_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		instr_t w;
		w.i_fields.opcode = op;
		w.i_fields.rs     = rs;
		w.i_fields.rt     = rt;
		w.i_fields.imm    = imm;
		return w;
	endfunction

	// 0 no writeback, 1 ALU pipe, 2 multiply pipe
	function automatic int pipe_of(instr_t w);
		if (w.r_fields.opcode == `PM_OP_ADDI)
			return 1;
		if (w.r_fields.opcode != `PM_OP_RTYPE)
			return 0;
		case (w.r_fields.funct)
			`PM_FN_ADD, `PM_FN_SUB, `PM_FN_AND, `PM_FN_OR: return 1;
			`PM_FN_MUL: return 2;
			default:    return 0;
		endcase
	endfunction

	function automatic logic [4:0] dest_of(instr_t w);
		if (w.r_fields.opcode == `PM_OP_ADDI)
			return w.i_fields.rt;
		return w.r_fields.rd;
	endfunction

	// operands are whatever has been committed by now
	function automatic logic [31:0] model_result(instr_t w);
		logic [31:0] a;
		logic [31:0] b;
		a = model_regs[w.r_fields.rs];
		b = model_regs[w.r_fields.rt];
		if (w.r_fields.opcode == `PM_OP_ADDI)
			return a + {16'h0000, w.i_fields.imm}; // zero extended
		case (w.r_fields.funct)
			`PM_FN_SUB: return a - b;
			`PM_FN_AND: return a & b;
			`PM_FN_OR:  return a | b;
			`PM_FN_MUL: return a * b; // low word
			default:    return a + b;
		endcase
	endfunction

	task automatic add_row(instr_t w, int gap, logic [31:0] exp, bit fixed);
		tbl_inst.push_back(w);
		tbl_gap.push_back(gap);
		tbl_exp.push_back(exp);
		tbl_fixed.push_back(fixed);
	endtask

	task automatic build_table();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
		logic [5:0] funct;
		// single results into an empty pipe
		add_row(r_word(`PM_FN_ADD, 3, 4, 20), 7, 32'd7, 1);
		add_row(r_word(`PM_FN_MUL, 5, 6, 21), 7, 32'd30, 1);
		// each ALU operation and addi
		add_row(r_word(`PM_FN_SUB, 2, 9, 22), 0, 32'hfffffff9, 1);
		add_row(r_word(`PM_FN_AND, 12, 10, 23), 0, 32'd8, 1);
		add_row(r_word(`PM_FN_OR, 12, 3, 24), 0, 32'd15, 1);
		add_row(i_word(`PM_OP_ADDI, 7, 25, 16'hfff0), 6, 32'h0000fff7, 1);
		// four muls back to back, the last two wrap past 32 bits
		add_row(r_word(`PM_FN_MUL, 7, 8, 26), 0, 32'd56, 1);
		add_row(r_word(`PM_FN_MUL, 9, 11, 27), 0, 32'd99, 1);
		add_row(r_word(`PM_FN_MUL, 22, 25, 28), 0, 32'hfff9003f, 1);
		add_row(r_word(`PM_FN_MUL, 22, 22, 29), 8, 32'h00000031, 1);
		// mul and add reach the queue together
		add_row(r_word(`PM_FN_MUL, 5, 7, 30), 2, 32'd35, 1);
		add_row(r_word(`PM_FN_ADD, 20, 21, 31), 8, 32'd37, 1);
		// nop, lw, sw, beq and an unknown funct
		add_row(32'h0000_0000, 0, 32'd0, 1);
		add_row(i_word(6'd35, 1, 18, 16'h0004), 0, 32'd0, 1);
		add_row(i_word(6'd43, 1, 18, 16'h0008), 0, 32'd0, 1);
		add_row(i_word(6'd4, 1, 2, 16'h0010), 0, 32'd0, 1);
		add_row(r_word(6'd3, 1, 2, 19), 10, 32'd0, 1);
		// dependent reads, each in the commit cycle of its source
		add_row(i_word(`PM_OP_ADDI, 20, 18, 16'h0100), 2, 32'h00000107, 1);
		add_row(r_word(`PM_FN_ADD, 18, 23, 17), 2, 32'h0000010f, 1);
		add_row(r_word(`PM_FN_MUL, 17, 17, 16), 5, 32'h00011ee1, 1);
		add_row(r_word(`PM_FN_ADD, 16, 21, 15), 4, 32'h00011eff, 1);
		// random rows into r0 to r14
		for (int k = 0; k < 5; k++)
		begin
			rs  = 5'($random(seed));
			imm = 16'($random(seed));
			add_row(i_word(`PM_OP_ADDI, rs, 5'(k), imm), int'($unsigned($random(seed)) % 3), 0, 0);
		end
		for (int k = 5; k < 15; k++)
		begin
			rs    = 5'($random(seed));
			rt    = 5'($random(seed));
			funct = (($random(seed) & 1) != 0) ? `PM_FN_MUL : `PM_FN_ADD;
			add_row(r_word(funct, rs, rt, 5'(k)), int'($unsigned($random(seed)) % 4), 0, 0);
		end
	endtask

	task automatic check_commit();
		wb_t exp;
		exp = '0;
		if (alu_sched[cyc].valid)
			pend_q.push_back(alu_sched[cyc]); // ALU ahead of mul on a tie
		if (mul_sched[cyc].valid)
			pend_q.push_back(mul_sched[cyc]);
		if (pend_q.size() != 0)
		begin
			exp = pend_q.pop_front(); // one commit per cycle
			model_regs[exp.dest] = exp.data;
		end
		if (o_wb.valid === 1'b1)
			commits_seen++;
		check_value("o_wb.valid", {31'b0, o_wb.valid}, {31'b0, exp.valid});
		if (exp.valid && o_wb.valid === 1'b1)
		begin
			check_value("o_wb.dest", {27'b0, o_wb.dest}, {27'b0, exp.dest});
			check_value("o_wb.data", o_wb.data, exp.data);
		end
	endtask

	// o_wb is stable at the falling edge, inputs change right after
	task automatic next_cycle();
		@(negedge clk);
		cyc++;
		check_commit();
	endtask

	task automatic issue_row(int i);
		int pipe;
		wb_t exp;
		pipe      = pipe_of(tbl_inst[i]);
		exp.valid = 1'b1;
		exp.dest  = dest_of(tbl_inst[i]);
		exp.data  = tbl_fixed[i] ? tbl_exp[i] : model_result(tbl_inst[i]);
		if (pipe == 1)
			alu_sched[cyc + 3] = exp;
		else if (pipe == 2)
			mul_sched[cyc + 6] = exp;
		if (pipe != 0)
			issued++;
		i_inst_valid = 1'b1;
		i_inst       = tbl_inst[i];
		next_cycle();
		i_inst_valid = 1'b0;
		repeat (tbl_gap[i]) next_cycle();
	endtask

	initial
	begin
		int waited;
		clk          = 1'b0;
		rst          = 1'b0;
		i_inst_valid = 1'b0;
		i_inst       = '0;
		cyc          = 0;
		issued       = 0;
		commits_seen = 0;
		errors       = 0;
		checks       = 0;
		seed         = 32'h2f6c;
		for (int c = 0; c < SCHED; c++)
		begin
			alu_sched[c] = '0;
			mul_sched[c] = '0;
		end
		for (int r = 0; r < `PM_NUM_REGS; r++)
			model_regs[r] = `PM_XLEN'(r);
		build_table();
		repeat (2) @(negedge clk);
		rst = 1'b1;
		repeat (4) next_cycle(); // quiet after reset
		for (int i = 0; i < tbl_inst.size(); i++)
			issue_row(i);
		waited = 0;
		while (commits_seen < issued && waited < DRAIN_LIMIT)
		begin
			next_cycle();
			waited++;
		end
		if (commits_seen < issued)
		begin
			errors++;
			$display("timeout: only %0d of %0d results were committed", commits_seen, issued);
		end
		repeat (10) next_cycle(); // nothing further may commit
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== pipemips.f ====
+incdir+common
common/pipemips_pkg.sv
logic/decode_issue.sv
logic/register_bank.sv
execute/alu_unit.sv
execute/mul_pipe.sv
logic/writeback_queue.sv
logic/pipemips.sv
tests/pipemips_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
TB_TOP     := pipemips_tb
RTL_TOP    := pipemips
FILELIST   := pipemips.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
